//--- mips_pipe.f
+incdir+test
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/hazard_unit.sv
hw/mips_pipe.sv
test/tb_mips_pipe.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mips_pipe testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_mips_pipe -f mips_pipe.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_mips_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- test/tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// xorshift32 step
function automatic word_t next_rand();
   rng_state = rng_state ^ (rng_state << 13);
   rng_state = rng_state ^ (rng_state >> 17);
   rng_state = rng_state ^ (rng_state << 5);
   return rng_state;
endfunction

// small register pool, r0 included, so dependencies are dense
function automatic reg_idx_t pick_reg();
   return reg_idx_t'(next_rand() % 8);
endfunction

function automatic funct_e pick_fn(input logic [2:0] sel);
   case (sel)
      3'd0:    return FN_ADD;
      3'd1:    return FN_SUB;
      3'd2:    return FN_AND;
      3'd3:    return FN_OR;
      default: return FN_SLT;
   endcase
endfunction

// instruction encoders
function automatic word_t enc_r(input funct_e fn, input reg_idx_t rs, input reg_idx_t rt,
                                input reg_idx_t rd);
   return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(input opcode_e op, input reg_idx_t rs, input reg_idx_t rt,
                                input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(input logic [25:0] idx);
   return {OP_J, idx};
endfunction

// 8 words reachable, random upper bits so the address wraps
function automatic logic [15:0] mem_offset(input word_t r);
   return {r[23:16], 3'b000, r[26:24], 2'b00};
endfunction

// random program, forward control flow only, self-jump at the end
function automatic void build_program();
   int       n;
   int       kind;
   int       span;
   int       tgt;
   word_t    r;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd;
   n        = 40 + int'(next_rand() % 21);
   prog_len = n;
   for (int i = 0; i < n - 1; i++) begin
      r    = next_rand();
      kind = int'(r[3:0]);
      rs   = pick_reg();
      rt   = pick_reg();
      rd   = pick_reg();
      // branch or jump lands at most 4 ahead, never past the end
      span = n - 1 - i;
      if (span > 4) begin
         span = 4;
      end
      tgt = i + 1 + int'(r[9:8]) % span;
      if (kind < 6) begin
         prog[i[IMEM_AW-1:0]] = enc_r(pick_fn(3'(r[14:12] % 5)), rs, rt, rd);
      end else if (kind < 9) begin
         prog[i[IMEM_AW-1:0]] = enc_i(OP_ADDI, rs, rt, r[31:16]);
      end else if (kind < 11) begin
         prog[i[IMEM_AW-1:0]] = enc_i(OP_LW, 5'd0, rt, mem_offset(r));
      end else if (kind < 13) begin
         prog[i[IMEM_AW-1:0]] = enc_i(OP_SW, 5'd0, rt, mem_offset(r));
      end else if (kind < 15) begin
         // same register on both sides gives a sure taken branch
         if (r[5:4] == 2'd0) begin
            rt = rs;
         end
         prog[i[IMEM_AW-1:0]] = enc_i(OP_BEQ, rs, rt, 16'(tgt - i - 1));
      end else begin
         prog[i[IMEM_AW-1:0]] = enc_j(26'(tgt));
      end
   end
   prog[IMEM_AW'(n - 1)] = enc_j(26'(n - 1));
endfunction

// r0 stays zero and never retires
function automatic void record_write(input reg_idx_t dst, input word_t val);
   if (dst != 5'd0) begin
      model_regs[dst] = val;
      exp_reg_q.push_back(dst);
      exp_data_q.push_back(val);
   end
endfunction

// instruction-level model, one instruction per step, no pipeline
task automatic run_model();
   word_t w;
   word_t a;
   word_t b;
   word_t sum;
   int    pc;
   int    pc_next;
   int    steps;
   logic  done;
   model_regs = '{default: '0};
   model_mem  = '{default: '0};
   exp_reg_q.delete();
   exp_data_q.delete();
   pc    = 0;
   steps = 0;
   done  = 1'b0;
   while (!done) begin
      w       = prog[pc[IMEM_AW-1:0]];
      a       = model_regs[w[25:21]];
      b       = model_regs[w[20:16]];
      sum     = a + {{16{w[15]}}, w[15:0]};
      pc_next = pc + 1;
      case (w[31:26])
         OP_RTYPE: begin
            case (w[5:0])
               FN_ADD:  record_write(w[15:11], a + b);
               FN_SUB:  record_write(w[15:11], a - b);
               FN_AND:  record_write(w[15:11], a & b);
               FN_OR:   record_write(w[15:11], a | b);
               FN_SLT:  record_write(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
               default: ;
            endcase
         end
         OP_ADDI: record_write(w[20:16], sum);
         // word index is byte address bits 7..2
         OP_LW:   record_write(w[20:16], model_mem[sum[7:2]]);
         OP_SW:   model_mem[sum[7:2]] = b;
         OP_BEQ: begin
            if (a == b) begin
               pc_next = pc + 1 + int'($signed(w[15:0]));
            end
         end
         OP_J: begin
            pc_next = int'(w[25:0]);
            done    = (pc_next == pc);
         end
         default: ;
      endcase
      pc = pc_next;
      steps++;
      if (!done && steps > 4 * IMEM_WORDS) begin
         fail_now("reference model never reached the self-jump");
      end
   end
endtask

`endif

//--- test/tb_mips_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipe import mips_isa_pkg::*; ();

   localparam word_t SEED         = 32'hccf3_6bb1;
   localparam int    NUM_PROGS    = 4;
   // cycles allowed between two retirements
   localparam int    WAIT_LIMIT   = 100;
   localparam int    QUIET_CYCLES = 50;

   logic               clk;
   logic               rst;
   logic               imem_we;
   logic [IMEM_AW-1:0] imem_addr;
   word_t              imem_data;
   logic               wb_valid;
   reg_idx_t           wb_reg;
   word_t              wb_data;

   // stimulus and model state
   word_t    rng_state;
   word_t    prog [IMEM_WORDS];
   int       prog_len;
   word_t    model_regs [REG_NUM];
   word_t    model_mem [DMEM_WORDS];
   // expected retirements, in order
   reg_idx_t exp_reg_q [$];
   word_t    exp_data_q [$];

   `include "tb_mips_model.svh"

   mips_pipe dut0 (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_imem_we   (imem_we),
      .i_imem_addr (imem_addr),
      .i_imem_data (imem_data),
      .o_wb_valid  (wb_valid),
      .o_wb_reg    (wb_reg),
      .o_wb_data   (wb_data)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at first failure");
   endtask

   task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is r%0d, expected r%0d", $time, name, got, exp);
         fail_now("register number mismatch");
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
         fail_now("data value mismatch");
      end
   endtask

   // program goes in through the load port while reset is high
   task automatic reset_and_load();
      @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < prog_len; i++) begin
         imem_we   = 1'b1;
         imem_addr = IMEM_AW'(i);
         imem_data = prog[i[IMEM_AW-1:0]];
         @(negedge clk);
      end
      imem_we   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      // pipeline, register file and data memory clear
      repeat (3) @(negedge clk);
      rst = 1'b0;
   endtask

   // next retirement, sampled on the falling edge
   task automatic expect_write(input reg_idx_t exp_reg, input word_t exp_data);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!wb_valid) begin
         if (waited == WAIT_LIMIT) begin
            fail_now("timed out waiting for a register write");
         end
         waited++;
         @(negedge clk);
      end
      check_reg("o_wb_reg", wb_reg, exp_reg);
      check_word("o_wb_data", wb_data, exp_data);
   endtask

   // parked on the self-jump, nothing may retire
   task automatic check_quiet();
      for (int c = 0; c < QUIET_CYCLES; c++) begin
         @(negedge clk);
         if (wb_valid) begin
            $display("write to r%0d at %0t ns after the self-jump", wb_reg, $time);
            fail_now("pipeline kept writing after the end of the program");
         end
      end
   endtask

   initial begin
      rst       = 1'b1;
      imem_we   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      rng_state = SEED;
      for (int p = 0; p < NUM_PROGS; p++) begin
         build_program();
         run_model();
         reset_and_load();
         for (int k = 0; k < exp_reg_q.size(); k++) begin
            expect_write(exp_reg_q[k], exp_data_q[k]);
         end
         check_quiet();
         $display("program %0d: %0d instructions, %0d writes checked",
                  p, prog_len, exp_reg_q.size());
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/mips_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipe import mips_isa_pkg::*, mips_ctrl_pkg::*; (
   input  wire logic               i_clk,
   input  wire logic               i_rst,
   input  wire logic               i_imem_we,
   input  wire logic [IMEM_AW-1:0] i_imem_addr,
   input  wire word_t              i_imem_data,
   output logic                    o_wb_valid,
   output reg_idx_t                o_wb_reg,
   output word_t                   o_wb_data
);

   // fetch/decode
   word_t    fet_2_dec_instr;
   word_t    fet_2_dec_pc4;
   logic     dec_2_fet_redirect;
   word_t    dec_2_fet_target;
   // decode to hazard unit
   reg_idx_t dec_2_hz_rs_num;
   reg_idx_t dec_2_hz_rt_num;
   logic     dec_2_hz_uses_rt;
   logic     dec_2_hz_branch;
   // decode/execute
   reg_idx_t dec_2_ex_rs_num;
   reg_idx_t dec_2_ex_rt_num;
   reg_idx_t dec_2_ex_dst;
   word_t    dec_2_ex_rs;
   word_t    dec_2_ex_rt;
   word_t    dec_2_ex_imm;
   alu_op_e  dec_2_ex_alu_op;
   logic     dec_2_ex_use_imm;
   logic     dec_2_ex_mem_rd;
   logic     dec_2_ex_mem_wr;
   logic     dec_2_ex_reg_we;
   wb_src_e  dec_2_ex_wb_src;
   // execute/memory
   word_t    ex_2_mem_alu;
   word_t    ex_2_mem_store;
   reg_idx_t ex_2_mem_dst;
   logic     ex_2_mem_reg_we;
   logic     ex_2_mem_rd;
   logic     ex_2_mem_wr;
   wb_src_e  ex_2_mem_wb_src;
   // writeback
   logic     wb_en;
   reg_idx_t wb_reg;
   word_t    wb_data;
   // hazard unit
   fwd_sel_e hz_2_ex_fwd_a;
   fwd_sel_e hz_2_ex_fwd_b;
   logic     hz_stall;

   fetch_stage inst_fetch_stage (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_stall     (hz_stall),
      .i_redirect  (dec_2_fet_redirect),
      .i_target    (dec_2_fet_target),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .o_instr     (fet_2_dec_instr),
      .o_pc4       (fet_2_dec_pc4)
   );

   decode_stage inst_decode_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_stall      (hz_stall),
      .i_instr      (fet_2_dec_instr),
      .i_pc4        (fet_2_dec_pc4),
      .i_wb_en      (wb_en),
      .i_wb_reg     (wb_reg),
      .i_wb_data    (wb_data),
      .o_redirect   (dec_2_fet_redirect),
      .o_target     (dec_2_fet_target),
      .o_rs_num     (dec_2_hz_rs_num),
      .o_rt_num     (dec_2_hz_rt_num),
      .o_uses_rt    (dec_2_hz_uses_rt),
      .o_is_branch  (dec_2_hz_branch),
      .o_ex_rs_num  (dec_2_ex_rs_num),
      .o_ex_rt_num  (dec_2_ex_rt_num),
      .o_ex_dst     (dec_2_ex_dst),
      .o_ex_rs      (dec_2_ex_rs),
      .o_ex_rt      (dec_2_ex_rt),
      .o_ex_imm     (dec_2_ex_imm),
      .o_ex_alu_op  (dec_2_ex_alu_op),
      .o_ex_use_imm (dec_2_ex_use_imm),
      .o_ex_mem_rd  (dec_2_ex_mem_rd),
      .o_ex_mem_wr  (dec_2_ex_mem_wr),
      .o_ex_reg_we  (dec_2_ex_reg_we),
      .o_ex_wb_src  (dec_2_ex_wb_src)
   );

   execute_stage inst_execute_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_ex_dst     (dec_2_ex_dst),
      .i_ex_rs      (dec_2_ex_rs),
      .i_ex_rt      (dec_2_ex_rt),
      .i_ex_imm     (dec_2_ex_imm),
      .i_ex_alu_op  (dec_2_ex_alu_op),
      .i_ex_use_imm (dec_2_ex_use_imm),
      .i_ex_mem_rd  (dec_2_ex_mem_rd),
      .i_ex_mem_wr  (dec_2_ex_mem_wr),
      .i_ex_reg_we  (dec_2_ex_reg_we),
      .i_ex_wb_src  (dec_2_ex_wb_src),
      .i_fwd_a      (hz_2_ex_fwd_a),
      .i_fwd_b      (hz_2_ex_fwd_b),
      .i_mem_alu    (ex_2_mem_alu),
      .i_wb_data    (wb_data),
      .o_mem_alu    (ex_2_mem_alu),
      .o_mem_store  (ex_2_mem_store),
      .o_mem_dst    (ex_2_mem_dst),
      .o_mem_reg_we (ex_2_mem_reg_we),
      .o_mem_rd     (ex_2_mem_rd),
      .o_mem_wr     (ex_2_mem_wr),
      .o_mem_wb_src (ex_2_mem_wb_src)
   );

   memory_stage inst_memory_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_mem_alu    (ex_2_mem_alu),
      .i_mem_store  (ex_2_mem_store),
      .i_mem_dst    (ex_2_mem_dst),
      .i_mem_reg_we (ex_2_mem_reg_we),
      .i_mem_rd     (ex_2_mem_rd),
      .i_mem_wr     (ex_2_mem_wr),
      .i_mem_wb_src (ex_2_mem_wb_src),
      .o_wb_en      (wb_en),
      .o_wb_reg     (wb_reg),
      .o_wb_data    (wb_data)
   );

   hazard_unit inst_hazard_unit (
      .i_id_rs      (dec_2_hz_rs_num),
      .i_id_rt      (dec_2_hz_rt_num),
      .i_id_uses_rt (dec_2_hz_uses_rt),
      .i_id_branch  (dec_2_hz_branch),
      .i_ex_rs      (dec_2_ex_rs_num),
      .i_ex_rt      (dec_2_ex_rt_num),
      .i_ex_dst     (dec_2_ex_dst),
      .i_ex_mem_rd  (dec_2_ex_mem_rd),
      .i_ex_reg_we  (dec_2_ex_reg_we),
      .i_mem_dst    (ex_2_mem_dst),
      .i_mem_reg_we (ex_2_mem_reg_we),
      .i_wb_reg     (wb_reg),
      .i_wb_en      (wb_en),
      .o_fwd_a      (hz_2_ex_fwd_a),
      .o_fwd_b      (hz_2_ex_fwd_b),
      .o_stall      (hz_stall)
   );

   // retirement ports, only real register writes
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_valid <= 1'b0;
      end else begin
         o_wb_valid <= wb_en && wb_reg != '0;
      end
   end

   always_ff @(posedge i_clk) begin
      o_wb_reg  <= wb_reg;
      o_wb_data <= wb_data;
   end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_isa_pkg::*, mips_ctrl_pkg::*; (
   input  wire reg_idx_t i_id_rs,
   input  wire reg_idx_t i_id_rt,
   input  wire logic     i_id_uses_rt,
   input  wire logic     i_id_branch,
   input  wire reg_idx_t i_ex_rs,
   input  wire reg_idx_t i_ex_rt,
   input  wire reg_idx_t i_ex_dst,
   input  wire logic     i_ex_mem_rd,
   input  wire logic     i_ex_reg_we,
   input  wire reg_idx_t i_mem_dst,
   input  wire logic     i_mem_reg_we,
   input  wire reg_idx_t i_wb_reg,
   input  wire logic     i_wb_en,
   output fwd_sel_e      o_fwd_a,
   output fwd_sel_e      o_fwd_b,
   output logic          o_stall
);

   logic ex_hits_rs;
   logic ex_hits_rt;
   logic mem_hits_rs;
   logic mem_hits_rt;
   logic load_use;
   logic branch_wait;

   // newest producer wins and r0 is never forwarded
   function automatic fwd_sel_e pick_fwd(input reg_idx_t src);
      if (i_mem_reg_we && i_mem_dst != '0 && i_mem_dst == src) begin
         return FWD_EXMEM;
      end else if (i_wb_en && i_wb_reg != '0 && i_wb_reg == src) begin
         return FWD_MEMWB;
      end
      return FWD_NONE;
   endfunction

   // re-evaluated on any producer change as well as on the source numbers
   always_comb begin
      o_fwd_a = pick_fwd(i_ex_rs);
      o_fwd_b = pick_fwd(i_ex_rt);
   end

   // decode sources against instructions in execute and memory
   assign ex_hits_rs  = i_ex_reg_we && i_ex_dst != '0 && i_ex_dst == i_id_rs;
   assign ex_hits_rt  = i_ex_reg_we && i_ex_dst != '0 && i_ex_dst == i_id_rt && i_id_uses_rt;
   assign mem_hits_rs = i_mem_reg_we && i_mem_dst != '0 && i_mem_dst == i_id_rs;
   assign mem_hits_rt = i_mem_reg_we && i_mem_dst != '0 && i_mem_dst == i_id_rt && i_id_uses_rt;

   // load data is not ready for execute next cycle
   assign load_use    = i_ex_mem_rd && (ex_hits_rs || ex_hits_rt);
   // beq compares in decode where only the writeback bypass reaches it
   assign branch_wait = i_id_branch && (ex_hits_rs || ex_hits_rt || mem_hits_rs || mem_hits_rt);

   assign o_stall = load_use || branch_wait;

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_isa_pkg::*, mips_ctrl_pkg::*; (
   input  wire logic     i_clk,
   input  wire logic     i_rst,
   input  wire word_t    i_mem_alu,
   input  wire word_t    i_mem_store,
   input  wire reg_idx_t i_mem_dst,
   input  wire logic     i_mem_reg_we,
   input  wire logic     i_mem_rd,
   input  wire logic     i_mem_wr,
   input  wire wb_src_e  i_mem_wb_src,
   output logic          o_wb_en,
   output reg_idx_t      o_wb_reg,
   output word_t         o_wb_data
);

   logic [DMEM_AW-1:0] idx;
   word_t              load_data;
   word_t              wb_alu;
   word_t              wb_load;
   wb_src_e            wb_src;
   word_t              dmem [DMEM_WORDS];

   // alu result is the byte address, wraps on the word index
   assign idx       = i_mem_alu[WORD_LSB +: DMEM_AW];
   assign load_data = i_mem_rd ? dmem[idx] : '0;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (i_mem_wr) begin
         dmem[idx] <= i_mem_store;
      end
   end

   // memory/writeback latch
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_en <= 1'b0;
         wb_src  <= WB_ALU;
      end else begin
         o_wb_en <= i_mem_reg_we;
         wb_src  <= i_mem_wb_src;
      end
   end

   always_ff @(posedge i_clk) begin
      o_wb_reg <= i_mem_dst;
      wb_alu   <= i_mem_alu;
      wb_load  <= load_data;
   end

   // writeback result
   assign o_wb_data = (wb_src == WB_MEM) ? wb_load : wb_alu;

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_isa_pkg::*, mips_ctrl_pkg::*; (
   input  wire logic     i_clk,
   input  wire logic     i_rst,
   input  wire reg_idx_t i_ex_dst,
   input  wire word_t    i_ex_rs,
   input  wire word_t    i_ex_rt,
   input  wire word_t    i_ex_imm,
   input  wire alu_op_e  i_ex_alu_op,
   input  wire logic     i_ex_use_imm,
   input  wire logic     i_ex_mem_rd,
   input  wire logic     i_ex_mem_wr,
   input  wire logic     i_ex_reg_we,
   input  wire wb_src_e  i_ex_wb_src,
   input  wire fwd_sel_e i_fwd_a,
   input  wire fwd_sel_e i_fwd_b,
   input  wire word_t    i_mem_alu,
   input  wire word_t    i_wb_data,
   output word_t         o_mem_alu,
   output word_t         o_mem_store,
   output reg_idx_t      o_mem_dst,
   output logic          o_mem_reg_we,
   output logic          o_mem_rd,
   output logic          o_mem_wr,
   output wb_src_e       o_mem_wb_src
);

   word_t op_a;
   word_t fwd_rt;
   word_t op_b;
   word_t result;

   // forwarding muxes
   always_comb begin
      case (i_fwd_a)
         FWD_EXMEM: op_a = i_mem_alu;
         FWD_MEMWB: op_a = i_wb_data;
         default:   op_a = i_ex_rs;
      endcase
      case (i_fwd_b)
         FWD_EXMEM: fwd_rt = i_mem_alu;
         FWD_MEMWB: fwd_rt = i_wb_data;
         default:   fwd_rt = i_ex_rt;
      endcase
   end

   // immediate replaces rt for addi, lw, sw
   assign op_b = i_ex_use_imm ? i_ex_imm : fwd_rt;

   always_comb begin
      case (i_ex_alu_op)
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         // signed compare
         ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
         default: result = op_a + op_b;
      endcase
   end

   // execute/memory control
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_mem_reg_we <= 1'b0;
         o_mem_rd     <= 1'b0;
         o_mem_wr     <= 1'b0;
         o_mem_wb_src <= WB_ALU;
      end else begin
         // writes to r0 dropped here
         o_mem_reg_we <= i_ex_reg_we && i_ex_dst != '0;
         o_mem_rd     <= i_ex_mem_rd;
         o_mem_wr     <= i_ex_mem_wr;
         o_mem_wb_src <= i_ex_wb_src;
      end
   end

   always_ff @(posedge i_clk) begin
      o_mem_alu   <= result;
      // store data takes the forwarded rt
      o_mem_store <= fwd_rt;
      o_mem_dst   <= i_ex_dst;
   end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_isa_pkg::*, mips_ctrl_pkg::*; (
   input  wire logic     i_clk,
   input  wire logic     i_rst,
   input  wire logic     i_stall,
   input  wire word_t    i_instr,
   input  wire word_t    i_pc4,
   input  wire logic     i_wb_en,
   input  wire reg_idx_t i_wb_reg,
   input  wire word_t    i_wb_data,
   output logic          o_redirect,
   output word_t         o_target,
   output reg_idx_t      o_rs_num,
   output reg_idx_t      o_rt_num,
   output logic          o_uses_rt,
   output logic          o_is_branch,
   output reg_idx_t      o_ex_rs_num,
   output reg_idx_t      o_ex_rt_num,
   output reg_idx_t      o_ex_dst,
   output word_t         o_ex_rs,
   output word_t         o_ex_rt,
   output word_t         o_ex_imm,
   output alu_op_e       o_ex_alu_op,
   output logic          o_ex_use_imm,
   output logic          o_ex_mem_rd,
   output logic          o_ex_mem_wr,
   output logic          o_ex_reg_we,
   output wb_src_e       o_ex_wb_src
);

   opcode_e  opc;
   funct_e   fn;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd;
   word_t    imm;
   word_t    rs_val;
   word_t    rt_val;
   // decoded control
   alu_op_e  alu_op;
   wb_src_e  wb_src;
   reg_idx_t dst;
   logic     use_imm;
   logic     mem_rd;
   logic     mem_wr;
   logic     reg_we;
   logic     is_jump;
   logic     taken;
   word_t    rf [REG_NUM];

   assign opc = opcode_e'(i_instr[OPC_LSB +: 6]);
   assign fn  = funct_e'(i_instr[FN_LSB +: 6]);
   assign rs  = i_instr[RS_LSB +: 5];
   assign rt  = i_instr[RT_LSB +: 5];
   assign rd  = i_instr[RD_LSB +: 5];
   // sign extended immediate
   assign imm = {{(32 - IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};

   always_comb begin
      alu_op      = ALU_ADD;
      wb_src      = WB_ALU;
      dst         = rt;
      use_imm     = 1'b0;
      mem_rd      = 1'b0;
      mem_wr      = 1'b0;
      reg_we      = 1'b0;
      is_jump     = 1'b0;
      o_is_branch = 1'b0;
      o_uses_rt   = 1'b0;
      case (opc)
         OP_RTYPE: begin
            dst       = rd;
            o_uses_rt = 1'b1;
            // unknown function codes, nop included, write nothing
            reg_we    = 1'b1;
            case (fn)
               FN_ADD:  alu_op = ALU_ADD;
               FN_SUB:  alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_SLT:  alu_op = ALU_SLT;
               default: reg_we = 1'b0;
            endcase
         end
         OP_ADDI: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
         end
         OP_LW: begin
            use_imm = 1'b1;
            mem_rd  = 1'b1;
            reg_we  = 1'b1;
            wb_src  = WB_MEM;
         end
         OP_SW: begin
            use_imm   = 1'b1;
            mem_wr    = 1'b1;
            o_uses_rt = 1'b1;
         end
         OP_BEQ: begin
            o_is_branch = 1'b1;
            o_uses_rt   = 1'b1;
         end
         OP_J:    is_jump = 1'b1;
         default: ;
      endcase
   end

   // rs field of j is target bits, not a source
   assign o_rs_num = is_jump ? '0 : rs;
   assign o_rt_num = rt;

   // register file, write first
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < REG_NUM; i++) begin
            rf[i] <= '0;
         end
      end else if (i_wb_en && i_wb_reg != '0) begin
         rf[i_wb_reg] <= i_wb_data;
      end
   end

   // same-cycle writeback bypass
   assign rs_val = (i_wb_en && i_wb_reg != '0 && i_wb_reg == rs) ? i_wb_data : rf[rs];
   assign rt_val = (i_wb_en && i_wb_reg != '0 && i_wb_reg == rt) ? i_wb_data : rf[rt];

   // branch and jump resolve here
   assign taken      = is_jump || (o_is_branch && rs_val == rt_val);
   assign o_redirect = taken && !i_stall;
   assign o_target   = is_jump ? {i_pc4[31:28], i_instr[JIDX_W-1:0], 2'b00}
                               : i_pc4 + {imm[29:0], 2'b00};

   // decode/execute control, bubble on stall
   always_ff @(posedge i_clk) begin
      if (i_rst || i_stall) begin
         o_ex_alu_op  <= ALU_ADD;
         o_ex_use_imm <= 1'b0;
         o_ex_mem_rd  <= 1'b0;
         o_ex_mem_wr  <= 1'b0;
         o_ex_reg_we  <= 1'b0;
         o_ex_wb_src  <= WB_ALU;
      end else begin
         o_ex_alu_op  <= alu_op;
         o_ex_use_imm <= use_imm;
         o_ex_mem_rd  <= mem_rd;
         o_ex_mem_wr  <= mem_wr;
         o_ex_reg_we  <= reg_we;
         o_ex_wb_src  <= wb_src;
      end
   end

   // payload
   always_ff @(posedge i_clk) begin
      o_ex_rs_num <= o_rs_num;
      o_ex_rt_num <= rt;
      o_ex_dst    <= dst;
      o_ex_rs     <= rs_val;
      o_ex_rt     <= rt_val;
      o_ex_imm    <= imm;
   end

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_isa_pkg::*; (
   input  wire logic               i_clk,
   input  wire logic               i_rst,
   input  wire logic               i_stall,
   input  wire logic               i_redirect,
   input  wire word_t              i_target,
   input  wire logic               i_imem_we,
   input  wire logic [IMEM_AW-1:0] i_imem_addr,
   input  wire word_t              i_imem_data,
   output word_t                   o_instr,
   output word_t                   o_pc4
);

   word_t pc;
   word_t pc4;
   word_t fetched;
   // program memory, loaded only during reset
   word_t imem [IMEM_WORDS];

   assign pc4     = pc + 32'd4;
   // word index wraps inside the memory
   assign fetched = imem[pc[WORD_LSB +: IMEM_AW]];

   always_ff @(posedge i_clk) begin
      if (i_rst && i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   // redirect wins, decode already masks it during a stall
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc <= '0;
      end else if (i_redirect) begin
         pc <= i_target;
      end else if (!i_stall) begin
         pc <= pc4;
      end
   end

   // fetch/decode latch
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_instr <= NOP_WORD;
         o_pc4   <= '0;
      end else if (i_redirect) begin
         // kill the wrongly fetched one
         o_instr <= NOP_WORD;
         o_pc4   <= pc4;
      end else if (!i_stall) begin
         o_instr <= fetched;
         o_pc4   <= pc4;
      end
   end

endmodule

`default_nettype wire

//--- hw/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

   // alu operations chosen in decode
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   // operand source in execute
   typedef enum logic [1:0] {
      FWD_NONE  = 2'd0,
      FWD_EXMEM = 2'd1,
      FWD_MEMWB = 2'd2
   } fwd_sel_e;

   // writeback value source
   typedef enum logic {
      WB_ALU = 1'b0,
      WB_MEM = 1'b1
   } wb_src_e;

endpackage

`default_nettype wire

//--- hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

   // data and instruction words
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_e;

   // r-type function codes, instr[5:0]
   typedef enum logic [5:0] {
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_SLT = 6'h2a
   } funct_e;

   // field positions
   localparam int OPC_LSB = 26;
   localparam int RS_LSB  = 21;
   localparam int RT_LSB  = 16;
   localparam int RD_LSB  = 11;
   localparam int FN_LSB  = 0;
   localparam int IMM_W   = 16;
   localparam int JIDX_W  = 26;

   // register file and memories
   localparam int REG_NUM    = 32;
   localparam int IMEM_WORDS = 64;
   localparam int DMEM_WORDS = 64;
   localparam int IMEM_AW    = 6;
   localparam int DMEM_AW    = 6;
   // byte address bit where the word index starts
   localparam int WORD_LSB   = 2;

   // all-zero word, decodes as no-op
   localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire
